/* build.f */
logic/fpu_pkg.sv
logic/fp_operands_if.sv
logic/fpu_operand_regs.sv
logic/fpu_add_sub.sv
logic/fpu_mul.sv
logic/fpu_sequencer.sv
logic/fpu_top.sv
+incdir+bench
bench/fpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the fpu testbench with verilator, run it, look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module fpu_tb -o fpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/fpu_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST PASSED" <<< "$sim_output"; then
  exit 0
fi
exit 1

/* bench/fpu_tb_vectors.svh */
//////////////////////////////
// fpu test vectors
// operation, operands, expected word, extra hold
//////////////////////////////
`ifndef fpu_tb_vectors_svh
`define fpu_tb_vectors_svh

localparam int max_vectors = 16;

string   vec_name     [max_vectors];
fpu_op_e vec_op       [max_vectors];
float_t  vec_a        [max_vectors];
float_t  vec_b        [max_vectors];
float_t  vec_expected [max_vectors];
// extra cycles start stays high after cmd_end
int      vec_hold     [max_vectors];
int      vector_count = 0;

task automatic add_vector(input string name, input fpu_op_e op, input float_t a,
                          input float_t b, input float_t expected, input int hold);
  vec_name[vector_count]     = name;
  vec_op[vector_count]       = op;
  vec_a[vector_count]        = a;
  vec_b[vector_count]        = b;
  vec_expected[vector_count] = expected;
  vec_hold[vector_count]     = hold;
  vector_count++;
endtask

// columns: name, operation, a, b, expected, hold
task automatic load_vectors();
  // 1.5 + 2.25 = 3.75, b scale wins, a shifted by one
  add_vector("add_align", op_add, 32'h3fc00000, 32'h40100000, 32'h40700000, 1);
  // 3.0 + 1.0 = 4.0 through the carry path
  add_vector("add_carry", op_add, 32'h40400000, 32'h3f800000, 32'h40800000, 0);
  // 1.0 - 1.75 = -0.75, one step left
  add_vector("sub_negative", op_sub, 32'h3f800000, 32'h3fe00000, 32'hbf400000, 2);
  // 1.0 - 0.9921875 = 2^-7, seven steps left
  add_vector("sub_cancel", op_sub, 32'h3f800000, 32'h3f7e0000, 32'h3c000000, 0);
  // -2.0 - 1.0 = -3.0
  add_vector("sub_neg_operand", op_sub, 32'hc0000000, 32'h3f800000, 32'hc0400000, 1);
  add_vector("sub_equal", op_sub, 32'h40a00000, 32'h40a00000, 32'h00000000, 0);
  // 2.5 + -2.5 must come out as +0
  add_vector("add_opposite", op_add, 32'h40200000, 32'hc0200000, 32'h00000000, 4);
  // 1.5 * -2.5 = -3.75
  add_vector("mul_exact_neg", op_mul, 32'h3fc00000, 32'hc0200000, 32'hc0700000, 0);
  // mantissa product 2^47 - 1, rounds up and carries into 2.0
  add_vector("mul_round_carry", op_mul, 32'h3fa1e58f, 32'h3fca6691, 32'h40000000, 3);
  // (2 - 2^-23)^2, round bit clear with sticky set
  add_vector("mul_sticky_down", op_mul, 32'h3fffffff, 32'h3fffffff, 32'h407ffffe, 0);
  // exact halfway cases, odd lsb goes up, even lsb stays
  add_vector("mul_tie_up_even", op_mul, 32'h3f800001, 32'h3fc00000, 32'h3fc00002, 5);
  add_vector("mul_tie_down_even", op_mul, 32'h3f800003, 32'h3fc00000, 32'h3fc00004, 0);
  add_vector("mul_zero", op_mul, 32'h00000000, 32'h40400000, 32'h00000000, 1);
endtask

`endif

/* bench/fpu_tb.sv */
//////////////////////////////
// fpu testbench
// table driven add, sub, mul with handshake checks
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_tb
  import fpu_pkg::*;
();

  localparam int clk_half         = 20;
  localparam int reset_cycles     = 16;
  // rising edges from start seen to cmd_end high
  localparam int expected_latency = 6;
  localparam int cmd_timeout      = 40;
  localparam int release_timeout  = 10;
  localparam int release_limit    = 2;

  logic    clk;
  logic    arst;
  float_t  a_operand;
  float_t  b_operand;
  fpu_op_e operation;
  logic    start;
  float_t  result;
  logic    cmd_end;
  logic    busy;

  int test_errors = 0;
  int error_count = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  `include "fpu_tb_vectors.svh"

  fpu_top UUT (
    .clk       (clk),
    .arst      (arst),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .operation (operation),
    .start     (start),
    .result    (result),
    .cmd_end   (cmd_end),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_half) clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    test_errors++;
  endtask

  // start rises on a falling edge and is sampled on the falling edges after it
  task automatic await_cmd_end(output int edges, output bit timed_out);
    int count;
    count = 0;
    while (!cmd_end && count < cmd_timeout) begin
      @(negedge clk);
      count++;
      if (!busy) begin
        report_error($sformatf("busy low after %0d cycles of a running command", count));
      end
    end
    timed_out = !cmd_end;
    edges = count - 1;
  endtask

  // cmd_end, busy and result must all stay put while start is held
  task automatic hold_start(input string name, input int cycles, input float_t held);
    repeat (cycles) begin
      @(negedge clk);
      if (!cmd_end) begin
        report_error("cmd_end dropped while start was still high");
      end
      if (!busy) begin
        report_error("busy dropped while start was still high");
      end
      if (result !== held) begin
        report_error($sformatf("Fail %s hold expected %h actual %h", name, held, result));
      end
    end
  endtask

  task automatic wait_until_idle(output int edges, output bit timed_out);
    int count;
    count = 0;
    while ((busy || cmd_end) && count < release_timeout) begin
      @(negedge clk);
      count++;
    end
    timed_out = busy || cmd_end;
    edges = count;
  endtask

  initial begin
    int     edges;
    bit     timed_out;
    bit     aborted;
    bit     value_ok;
    float_t actual;

    arst      = 1'b1;
    start     = 1'b0;
    a_operand = '0;
    b_operand = '0;
    operation = op_add;
    aborted   = 1'b0;
    load_vectors();

    repeat (reset_cycles) @(negedge clk);
    arst = 1'b0;
    @(negedge clk);

    // quiet outputs out of reset
    test_errors = 0;
    if (busy !== 1'b0 || cmd_end !== 1'b0) begin
      report_error("busy or cmd_end is not low after reset");
    end
    if (result !== '0) begin
      $display("Fail reset_state expected %h actual %h", 32'h0, result);
      test_errors++;
    end else if (test_errors == 0) begin
      $display("Pass reset_state");
    end
    if (test_errors == 0) tests_passed++;
    else tests_failed++;
    error_count += test_errors;

    for (int i = 0; i < vector_count && !aborted; i++) begin
      test_errors = 0;
      value_ok    = 1'b0;
      // inputs change on the falling edge and hold until cmd_end
      a_operand = vec_a[i];
      b_operand = vec_b[i];
      operation = vec_op[i];
      start     = 1'b1;

      await_cmd_end(edges, timed_out);
      actual = result;
      if (timed_out) begin
        report_error($sformatf("cmd_end never rose in %s", vec_name[i]));
        aborted = 1'b1;
      end else begin
        if (edges != expected_latency) begin
          report_error($sformatf("Fail %s latency expected %0d actual %0d",
                                 vec_name[i], expected_latency, edges));
        end
        if (actual === vec_expected[i]) begin
          value_ok = 1'b1;
        end
        // the host may change the inputs once cmd_end is high
        a_operand = ~vec_a[i];
        b_operand = ~vec_b[i];
        operation = (vec_op[i] == op_mul) ? op_add : op_mul;
        hold_start(vec_name[i], vec_hold[i], actual);
        start = 1'b0;
        wait_until_idle(edges, timed_out);
        if (timed_out) begin
          report_error($sformatf("busy or cmd_end stuck high after start fell in %s",
                                 vec_name[i]));
          aborted = 1'b1;
        end else if (edges > release_limit) begin
          report_error($sformatf("busy and cmd_end took %0d cycles to fall", edges));
        end
        // result keeps the command's value until the next command
        if (result !== actual) begin
          report_error($sformatf("Fail %s idle expected %h actual %h",
                                 vec_name[i], actual, result));
        end
      end

      // one closing line per test
      if (aborted) begin
        $display("%s stopped on a timeout", vec_name[i]);
      end else if (!value_ok) begin
        $display("Fail %s expected %h actual %h", vec_name[i], vec_expected[i], actual);
        test_errors++;
      end else if (test_errors != 0) begin
        $display("%s gave the right word but %0d handshake checks failed",
                 vec_name[i], test_errors);
      end else begin
        $display("Pass %s result %h", vec_name[i], actual);
      end
      if (test_errors == 0) tests_passed++;
      else tests_failed++;
      error_count += test_errors;
    end

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
    if (error_count == 0 && !aborted) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/fpu_top.sv */
//////////////////////////////
// fpu top
// add, sub, mul under a start/cmd_end handshake
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_top
  import fpu_pkg::*;
(
  input  logic    clk,
  input  logic    arst,
  input  float_t  a_operand,
  input  float_t  b_operand,
  input  fpu_op_e operation,
  input  logic    start,
  output float_t  result,
  output logic    cmd_end,
  output logic    busy
);

  logic   load_operands;
  logic   subtract;
  float_t sum;
  float_t product;

  // registered operand fields shared by both datapaths
  fp_operands_if ops ();

  // operation is held stable by the host for the whole command
  assign subtract = (operation == op_sub);

  fpu_operand_regs u_operand_regs (
    .clk           (clk),
    .arst          (arst),
    .load_operands (load_operands),
    .a_operand     (a_operand),
    .b_operand     (b_operand),
    .ops           (ops.source)
  );

  fpu_add_sub u_add_sub (
    .ops      (ops.sink),
    .subtract (subtract),
    .sum      (sum)
  );

  fpu_mul u_mul (
    .ops     (ops.sink),
    .product (product)
  );

  fpu_sequencer u_sequencer (
    .clk           (clk),
    .arst          (arst),
    .start         (start),
    .operation     (operation),
    .sum           (sum),
    .product       (product),
    .load_operands (load_operands),
    .result        (result),
    .cmd_end       (cmd_end),
    .busy          (busy)
  );

endmodule

`default_nettype wire

/* logic/fpu_sequencer.sv */
//////////////////////////////
// fpu sequencer
// command fsm, arithmetic fsm, result register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer
  import fpu_pkg::*;
(
  input  logic    clk,
  input  logic    arst,
  input  logic    start,
  input  fpu_op_e operation,
  input  float_t  sum,
  input  float_t  product,
  output logic    load_operands,
  output float_t  result,
  output logic    cmd_end,
  output logic    busy
);

  main_state_e  main_state;
  main_state_e  main_next;
  arith_state_e arith_state;
  arith_state_e arith_next;
  // handshake between the two machines
  logic         start_arith;
  logic         arith_done;

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      main_state  <= main_idle_st;
      arith_state <= arith_idle_st;
    end else begin
      main_state  <= main_next;
      arith_state <= arith_next;
    end
  end

  // command level: wait for done, wait for done to clear, wait for start low
  always_comb begin
    main_next = main_state;
    case (main_state)
      main_idle_st:
        if (start) main_next = main_wait_st;
      main_wait_st:
        if (arith_done) main_next = main_finish_st;
      main_finish_st:
        if (!arith_done) main_next = main_wait_start_low_st;
      main_wait_start_low_st:
        if (!start) main_next = main_idle_st;
      default:
        main_next = main_idle_st;
    endcase
  end

  // handshake outputs follow the next state
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      start_arith <= 1'b0;
      cmd_end     <= 1'b0;
      busy        <= 1'b0;
    end else begin
      start_arith <= (main_next == main_wait_st);
      cmd_end     <= (main_next == main_wait_start_low_st);
      busy        <= (main_next != main_idle_st);
    end
  end

  // load, one operation step, then hold result-valid until start_arith drops
  always_comb begin
    arith_next = arith_state;
    case (arith_state)
      arith_idle_st:
        if (start_arith) arith_next = arith_load_operands_st;
      arith_load_operands_st:
        case (operation)
          op_sub:  arith_next = arith_sub_st;
          op_mul:  arith_next = arith_mul_st;
          default: arith_next = arith_add_st;
        endcase
      arith_add_st,
      arith_sub_st,
      arith_mul_st:
        arith_next = arith_result_valid_st;
      arith_result_valid_st:
        if (!start_arith) arith_next = arith_idle_st;
      default:
        arith_next = arith_idle_st;
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      arith_done <= 1'b0;
    end else begin
      arith_done <= (arith_next == arith_result_valid_st);
    end
  end

  // operands are captured on the edge that enters the load state
  assign load_operands = (arith_next == arith_load_operands_st);

  // result stays put until the next command reaches result-valid
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      result <= '0;
    end else if (arith_state == arith_result_valid_st) begin
      case (operation)
        op_mul:  result <= product;
        default: result <= sum;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/fpu_mul.sv */
//////////////////////////////
// multiply datapath
// product, normalize, round to nearest even
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_mul
  import fpu_pkg::*;
(
  fp_operands_if.sink ops,
  output float_t product
);

  product_t    raw_prod;
  product_t    norm_prod;
  exp_t        exp_sum;
  exp_t        exp_norm;
  exp_t        exp_final;
  logic        round_bit;
  logic        sticky;
  logic        round_up;
  logic [24:0] rounded;
  logic [23:0] mant_final;
  logic        res_sign;
  logic        is_zero;

  // hidden bit and fraction only, guard bits play no part here
  assign raw_prod = ops.a_mant[23:0] * ops.b_mant[23:0];

  // both exponents carry a bias, take one off
  assign exp_sum  = ops.a_exp + ops.b_exp - exp_t'(exp_bias);
  assign res_sign = ops.a_sign ^ ops.b_sign;

  // product lies in [1,4), top bit set means the value is 1x.xxx
  assign norm_prod = raw_prod[47] ? raw_prod : raw_prod << 1;
  assign exp_norm  = raw_prod[47] ? exp_sum + 8'd1 : exp_sum;

  // kept mantissa is norm_prod[47:24]
  assign round_bit = norm_prod[23];
  assign sticky    = |norm_prod[22:0];
  // above half rounds up, exact half rounds to an even lsb
  assign round_up  = round_bit && (sticky || norm_prod[24]);

  assign rounded = {1'b0, norm_prod[47:24]} + {24'd0, round_up};

  // rounding carry out, renormalize
  assign mant_final = rounded[24] ? rounded[24:1] : rounded[23:0];
  assign exp_final  = rounded[24] ? exp_norm + 8'd1 : exp_norm;

  // a zero operand forces a signed zero
  assign is_zero = (ops.a_exp == '0) || (ops.b_exp == '0);

  assign product = is_zero ? {res_sign, 31'd0}
                           : {res_sign, exp_final, mant_final[frac_width-1:0]};

endmodule

`default_nettype wire

/* logic/fpu_add_sub.sv */
//////////////////////////////
// add/subtract datapath
// align, signed add, normalize
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_add_sub
  import fpu_pkg::*;
(
  fp_operands_if.sink ops,
  input  logic   subtract,
  output float_t sum
);

  logic       a_ge_b;
  exp_t       shift_amt;
  exp_t       exp_pre;
  mant_t      a_aligned;
  mant_t      b_aligned;
  mant_t      a_signed;
  mant_t      b_signed;
  mant_t      raw_sum;
  mant_t      abs_sum;
  mant_t      norm_mant;
  exp_t       norm_exp;
  logic       res_sign;
  logic [5:0] zcount;

  // the larger exponent sets the result scale
  assign a_ge_b    = ops.a_exp >= ops.b_exp;
  assign shift_amt = a_ge_b ? ops.a_exp - ops.b_exp : ops.b_exp - ops.a_exp;
  assign exp_pre   = a_ge_b ? ops.a_exp : ops.b_exp;

  // smaller operand moves right, low bits are dropped
  assign a_aligned = a_ge_b ? ops.a_mant : ops.a_mant >> shift_amt;
  assign b_aligned = a_ge_b ? ops.b_mant >> shift_amt : ops.b_mant;

  // two's complement of negative operands
  assign a_signed = ops.a_sign ? ~a_aligned + 1'b1 : a_aligned;
  assign b_signed = ops.b_sign ? ~b_aligned + 1'b1 : b_aligned;

  assign raw_sum = subtract ? a_signed - b_signed : a_signed + b_signed;

  // bit 25 is the sign guard, bit 24 holds a carry out of the hidden bit
  assign res_sign = raw_sum[25];
  assign abs_sum  = res_sign ? ~raw_sum + 1'b1 : raw_sum;

  // 6 pad bits plus 2 guard bits sit above the hidden bit position
  assign zcount = lzc({6'b000000, abs_sum}) - 6'd8;

  always_comb begin
    if (abs_sum[24]) begin
      // carry, one step right
      norm_mant = abs_sum >> 1;
      norm_exp  = exp_pre + 8'd1;
    end else begin
      // cancellation, bring the leading one back to bit 23
      norm_mant = abs_sum << zcount;
      norm_exp  = exp_pre - {2'b00, zcount};
    end
  end

  // exact cancellation gives +0
  assign sum = (abs_sum == '0) ? '0 : {res_sign, norm_exp, norm_mant[frac_width-1:0]};

endmodule

`default_nettype wire

/* logic/fpu_operand_regs.sv */
//////////////////////////////
// operand registers
// split ieee operands into fields and hold them
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fpu_operand_regs
  import fpu_pkg::*;
(
  input  logic  clk,
  input  logic  arst,
  input  logic  load_operands,
  input  float_t a_operand,
  input  float_t b_operand,
  fp_operands_if.source ops
);

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      ops.a_mant <= '0;
      ops.a_exp  <= '0;
      ops.a_sign <= 1'b0;
      ops.b_mant <= '0;
      ops.b_exp  <= '0;
      ops.b_sign <= 1'b0;
    end else if (load_operands) begin
      // guard bits clear, hidden bit only for a non-zero exponent
      ops.a_mant <= {2'b00, a_operand[30:frac_width] != '0, a_operand[frac_width-1:0]};
      ops.a_exp  <= a_operand[30:frac_width];
      ops.a_sign <= a_operand[31];
      ops.b_mant <= {2'b00, b_operand[30:frac_width] != '0, b_operand[frac_width-1:0]};
      ops.b_exp  <= b_operand[30:frac_width];
      ops.b_sign <= b_operand[31];
    end
  end

endmodule

`default_nettype wire

/* logic/fp_operands_if.sv */
//////////////////////////////
// operand bundle
// unpacked a and b operands for the datapaths
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface fp_operands_if import fpu_pkg::*; ();

  mant_t a_mant;
  exp_t  a_exp;
  logic  a_sign;
  mant_t b_mant;
  exp_t  b_exp;
  logic  b_sign;

  // register side
  modport source (output a_mant, a_exp, a_sign, b_mant, b_exp, b_sign);
  // arithmetic side
  modport sink (input a_mant, a_exp, a_sign, b_mant, b_exp, b_sign);

endinterface

`default_nettype wire

/* logic/fpu_pkg.sv */
//////////////////////////////
// fpu package
// shared widths, encodings and leading-zero count
//////////////////////////////
`default_nettype none

package fpu_pkg;

  // ieee single word laid out as sign, exponent, fraction
  typedef logic [31:0] float_t;
  // biased exponent
  typedef logic [7:0] exp_t;
  // sign guard, carry guard, hidden bit and 23 fraction bits
  typedef logic [25:0] mant_t;
  // raw product of two 24 bit mantissas
  typedef logic [47:0] product_t;

  localparam int exp_bias   = 127;
  localparam int frac_width = 23;

  typedef enum logic [1:0] {
    op_add,
    op_sub,
    op_mul
  } fpu_op_e;

  // command level sequencing
  typedef enum logic [1:0] {
    main_idle_st,
    main_wait_st,
    main_finish_st,
    main_wait_start_low_st
  } main_state_e;

  // datapath sequencing, one pass per command
  typedef enum logic [2:0] {
    arith_idle_st,
    arith_load_operands_st,
    arith_add_st,
    arith_sub_st,
    arith_mul_st,
    arith_result_valid_st
  } arith_state_e;

  // number of zeros above the highest set bit, 32 for an all-zero word
  function automatic logic [5:0] lzc(input logic [31:0] word);
    logic [5:0] count;
    count = 6'd32;
    // scan up from the lsb, so the highest set bit is the last to write
    for (int i = 0; i < 32; i++) begin
      if (word[i]) begin
        count = 6'(31 - i);
      end
    end
    return count;
  endfunction

endpackage

`default_nettype wire
